/* Bender.yml */
package:
  name: ecc_secded

sources:
  - include_dirs:
      - include
    files:
      - verilog/ecc_code_pkg.sv
      - verilog/ecc_stream_pkg.sv
      - verilog/ecc_encoder.sv
      - verilog/ecc_syndrome_decoder.sv
      - verilog/ecc_input_buffer.sv
      - verilog/ecc_check_pipe.sv
      - verilog/ecc_secded_top.sv
      - target: test
        files:
          - test/tb_clock_gen.sv
          - test/ecc_secded_tb.sv

/* ecc_secded_top.f */
+incdir+include
verilog/ecc_code_pkg.sv
verilog/ecc_stream_pkg.sv
verilog/ecc_encoder.sv
verilog/ecc_syndrome_decoder.sv
verilog/ecc_input_buffer.sv
verilog/ecc_check_pipe.sv
verilog/ecc_secded_top.sv
test/tb_clock_gen.sv
test/ecc_secded_tb.sv

/* include/ecc_defs.svh */
`ifndef ECC_DEFS_SVH
`define ECC_DEFS_SVH

// ========================================
// SECDED code geometry
// ========================================

// data bits carried by one codeword
`define ECC_DATA_WIDTH 89

// seven Hamming check bits plus the overall parity bit
`define ECC_PARITY_WIDTH 8

// Hamming positions run from 1 up to ECC_LAST_POSITION
`define ECC_POS_WIDTH 7
`define ECC_LAST_POSITION 96

// input buffer depth, also the credit count held on each side after reset
`define ECC_CREDITS 4

`endif

/* test/ecc_secded_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ecc_defs.svh"

module ecc_secded_tb
    import ecc_code_pkg::*;
    import ecc_stream_pkg::*;
();

    localparam int CREDITS     = `ECC_CREDITS;
    localparam int MAX_VECTORS = 64;
    localparam int ROUNDS      = 2; // the vector list is streamed this many times

    logic        clk;
    logic        rst;
    ecc_data_t   enc_data;
    ecc_parity_t enc_parity;
    logic        in_valid;
    ecc_req_t    in_req;
    logic        in_credit;
    logic        out_credit;
    logic        out_valid;
    ecc_rsp_t    out_rsp;

    string       vec_name     [MAX_VECTORS];
    ecc_data_t   vec_data     [MAX_VECTORS];
    ecc_parity_t vec_parity   [MAX_VECTORS];
    logic        vec_bypass   [MAX_VECTORS];
    ecc_data_t   vec_exp_data [MAX_VECTORS];
    logic        vec_exp_sbit [MAX_VECTORS];
    logic        vec_exp_dbit [MAX_VECTORS];
    int          num_vectors;

    int     expect_q [$]; // vector index of every request still in flight
    int     return_q [$]; // cycle in which each owed output credit goes back
    int     error_count;
    int     check_count;
    int     rsp_count;
    int     up_credits;
    int     outstanding;
    int     cycle_count;
    int     timeout_limit;
    int     last_due;
    integer seed;

    tb_clock_gen u_clock_gen (
        .clk (clk)
    );

    ecc_secded_top u_ecc_secded_top (
        .clk        (clk),
        .rst        (rst),
        .enc_data   (enc_data),
        .enc_parity (enc_parity),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_rsp    (out_rsp)
    );

    task automatic check_value(input string test_name, input string what,
                               input logic [127:0] expected, input logic [127:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic load_vectors();
        int           fd;
        int           got;
        int           fields;
        string        line;
        string        name;
        logic [127:0] f_data, f_parity, f_bypass, f_exp_data, f_exp_sbit, f_exp_dbit;
        num_vectors = 0;
        fd = $fopen("test/ecc_secded_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file test/ecc_secded_vectors.txt");
            error_count++;
            return;
        end
        while (!$feof(fd) && num_vectors < MAX_VECTORS) begin
            got = $fgets(line, fd);
            if (got == 0 || line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h %h %h %h %h", name, f_data, f_parity,
                             f_bypass, f_exp_data, f_exp_sbit, f_exp_dbit);
            if (fields == 7) begin
                vec_name[num_vectors]     = name;
                vec_data[num_vectors]     = f_data[`ECC_DATA_WIDTH-1:0];
                vec_parity[num_vectors]   = f_parity[`ECC_PARITY_WIDTH-1:0];
                vec_bypass[num_vectors]   = f_bypass[0];
                vec_exp_data[num_vectors] = f_exp_data[`ECC_DATA_WIDTH-1:0];
                vec_exp_sbit[num_vectors] = f_exp_sbit[0];
                vec_exp_dbit[num_vectors] = f_exp_dbit[0];
                num_vectors++;
            end else if (fields > 0) begin
                $display("vector line could not be read: %s", line);
                error_count++;
            end
        end
        $fclose(fd);
    endtask

    // the file parity of every clean word must match the write encoder
    task automatic check_encoder();
        for (int i = 0; i < num_vectors; i++) begin
            if (!vec_bypass[i] && !vec_exp_sbit[i] && !vec_exp_dbit[i]) begin
                @(posedge clk);
                #1;
                enc_data = vec_data[i];
                #2;
                check_value(vec_name[i], "enc_parity", vec_parity[i], enc_parity);
            end
        end
    endtask

    task automatic issue_vectors();
        int idx;
        int issued;
        issued = 0;
        while (issued < num_vectors * ROUNDS) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            if (up_credits > 0) begin // one beat per held credit
                idx           = issued % num_vectors;
                in_valid      = 1'b1;
                in_req.data   = vec_data[idx];
                in_req.parity = vec_parity[idx];
                in_req.bypass = vec_bypass[idx];
                up_credits--;
                expect_q.push_back(idx);
                issued++;
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // ========================================
    // upstream credits and downstream model
    // ========================================

    always @(posedge clk) begin
        if (!rst && in_credit) begin
            up_credits++;
            if (up_credits > CREDITS) begin
                $display("upstream credit count rose above %0d", CREDITS);
                error_count++;
            end
        end
    end

    always @(posedge clk) begin : downstream_model
        int   idx;
        int   delay;
        int   due;
        logic seen;
        seen = 1'b0;
        if (!rst) begin
            if (out_valid) begin
                seen = 1'b1;
                rsp_count++;
                outstanding++;
                if (outstanding > CREDITS) begin
                    $display("more than %0d responses arrived without credits", CREDITS);
                    error_count++;
                end
                if (expect_q.size() == 0) begin
                    $display("out_valid was raised with no request in flight");
                    error_count++;
                end else begin
                    idx = expect_q.pop_front(); // responses must come back in issue order
                    check_value(vec_name[idx], "data", vec_exp_data[idx], out_rsp.data);
                    check_value(vec_name[idx], "sbit_err", vec_exp_sbit[idx], out_rsp.sbit_err);
                    check_value(vec_name[idx], "dbit_err", vec_exp_dbit[idx], out_rsp.dbit_err);
                end
            end
            if (out_credit) outstanding--;
        end
        #1;
        if (seen) begin
            delay = $unsigned($random(seed)) % 4;
            due   = cycle_count + delay;
            if (due <= last_due) due = last_due + 1; // at most one return per cycle
            last_due = due;
            return_q.push_back(due);
        end
        if (return_q.size() > 0 && return_q[0] <= cycle_count) begin
            void'(return_q.pop_front());
            out_credit = 1'b1;
        end else begin
            out_credit = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("timeout: the run went past %0d cycles without finishing", timeout_limit);
            $display("errors: %0d of %0d checks failed", error_count, check_count);
            $display("Some tests failed");
            $finish;
        end
    end

    // ========================================
    // main sequence
    // ========================================

    initial begin
        rst           = 1'b1;
        enc_data      = '0;
        in_valid      = 1'b0;
        in_req        = '0;
        out_credit    = 1'b0;
        seed          = 32'h92f9_e78f;
        error_count   = 0;
        check_count   = 0;
        rsp_count     = 0;
        outstanding   = 0;
        cycle_count   = 0;
        last_due      = 0;
        timeout_limit = 0;
        up_credits    = CREDITS;
        load_vectors();
        if (num_vectors == 0) begin
            $display("no vectors were loaded, so nothing was tested");
            $display("Some tests failed");
            $finish;
        end
        timeout_limit = 40 * num_vectors * ROUNDS + 100;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_encoder();
        issue_vectors();
        while (rsp_count < num_vectors * ROUNDS || outstanding != 0 || up_credits != CREDITS) begin
            @(posedge clk);
            #2;
        end
        $display("errors: %0d of %0d checks failed", error_count, check_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/ecc_secded_vectors.txt */
# name data parity bypass expected_data expected_sbit expected_dbit
# all fields after the name are hex, data words are 89 bits wide
clean_zero 0 00 0 0 0 0
clean_bit0 1 83 0 1 0 0
clean_bit10 400 8f 0 400 0 0
clean_bit26 4000000 a1 0 4000000 0 0
clean_bit57 200000000000000 c1 0 200000000000000 0 0
clean_bit88 10000000000000000000000 e0 0 10000000000000000000000 0 0
clean_bits0_88 10000000000000000000001 63 0 10000000000000000000001 0 0
clean_small b 01 0 b 0 0
clean_ones 1ffffffffffffffffffffff 1f 0 1ffffffffffffffffffffff 0 0
sbit_zero_d5 20 00 0 0 1 0
sbit_zero_d10 400 00 0 0 1 0
sbit_zero_d11 800 00 0 0 1 0
sbit_zero_d25 2000000 00 0 0 1 0
sbit_zero_d56 100000000000000 00 0 0 1 0
sbit_zero_d87 8000000000000000000000 00 0 0 1 0
sbit_small_d1 9 01 0 b 1 0
sbit_ones_d0 1fffffffffffffffffffffe 1f 0 1ffffffffffffffffffffff 1 0
sbit_ones_d44 1ffffffffffefffffffffff 1f 0 1ffffffffffffffffffffff 1 0
sbit_ones_d88 ffffffffffffffffffffff 1f 0 1ffffffffffffffffffffff 1 0
sbit_small_p7 b 81 0 b 1 0
sbit_small_p3 b 09 0 b 1 0
sbit_ones_p0 1ffffffffffffffffffffff 1e 0 1ffffffffffffffffffffff 1 0
sbit_zero_p6 0 40 0 0 1 0
sbit_zero_p7 0 80 0 0 1 0
dbit_ones_d0_d1 1fffffffffffffffffffffc 1f 0 1fffffffffffffffffffffc 0 1
dbit_zero_d2_d88 10000000000000000000004 00 0 10000000000000000000004 0 1
dbit_small_p0_p1 b 02 0 b 0 1
dbit_d0_p0 1 01 0 1 0 1
dbit_zero_p6_p7 0 c0 0 0 0 1
dbit_zero_out_of_range 0 7f 0 0 0 1
bypass_small b ff 1 b 0 0
bypass_ones 1ffffffffffffffffffffff 00 1 1ffffffffffffffffffffff 0 0
bypass_sbit 9 01 1 9 0 0
bypass_out_of_range 0 7f 1 0 0 0

/* test/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 4; // 8 ns period

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* verilog/ecc_check_pipe.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ecc_defs.svh"

module ecc_check_pipe
    import ecc_code_pkg::*;
    import ecc_stream_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     buf_valid,
    input  ecc_req_t buf_req,
    output logic     buf_pop,
    input  logic     out_credit,
    output logic     out_valid,
    output ecc_rsp_t out_rsp
);

    localparam int CNT_W = $clog2(`ECC_CREDITS + 1);

    logic             s1_valid;
    ecc_req_t         s1_req;
    ecc_syndrome_u    s1_syndrome;
    logic             s2_valid;
    ecc_rsp_t         s2_rsp;
    ecc_parity_t      read_parity;
    ecc_data_t        corr_mask;
    logic             corr_sbit;
    logic             corr_dbit;
    logic [CNT_W-1:0] credit_cnt;
    logic             out_fire;
    logic             s2_ready;
    logic             s1_ready;
    logic             s1_advance;

    ecc_encoder u_read_encoder (
        .data   (buf_req.data),
        .parity (read_parity)
    );

    ecc_syndrome_decoder u_syndrome_decoder (
        .syndrome (s1_syndrome),
        .mask     (corr_mask),
        .sbit_err (corr_sbit),
        .dbit_err (corr_dbit)
    );

    // ========================================
    // flow control
    // ========================================

    assign out_fire   = s2_valid && (credit_cnt != '0);
    assign s2_ready   = !s2_valid || out_fire;
    assign s1_ready   = !s1_valid || s2_ready;
    assign s1_advance = s1_valid && s2_ready;
    assign buf_pop    = buf_valid && s1_ready;

    assign out_valid = out_fire;
    assign out_rsp   = s2_rsp;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            credit_cnt <= CNT_W'(`ECC_CREDITS);
        end else begin
            if (s1_ready) s1_valid <= buf_valid;
            if (s2_ready) s2_valid <= s1_valid;
            case ({out_fire, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt; // spend and return cancel
            endcase
        end
    end

    // ========================================
    // payload stages
    // ========================================

    always_ff @(posedge clk) begin
        if (buf_pop) begin
            s1_req          <= buf_req;
            s1_syndrome.raw <= buf_req.parity ^ read_parity;
        end
        if (s1_advance) begin
            s2_rsp.data     <= s1_req.bypass ? s1_req.data : s1_req.data ^ corr_mask;
            s2_rsp.sbit_err <= corr_sbit && !s1_req.bypass;
            s2_rsp.dbit_err <= corr_dbit && !s1_req.bypass;
        end
    end

endmodule

`default_nettype wire

/* verilog/ecc_code_pkg.sv */
`default_nettype none

`include "ecc_defs.svh"

package ecc_code_pkg;

    typedef logic [`ECC_DATA_WIDTH-1:0]   ecc_data_t;
    typedef logic [`ECC_PARITY_WIDTH-1:0] ecc_parity_t;

    typedef struct packed {
        logic                      overall;  // even-weight parity bit
        logic [`ECC_POS_WIDTH-1:0] position; // Hamming position of the error
    } ecc_syndrome_fields_t;

    // the same syndrome seen as a raw word or split into its two parts
    typedef union packed {
        ecc_parity_t          raw;
        ecc_syndrome_fields_t fields;
    } ecc_syndrome_u;

    // Hamming position of data bit index, skipping the power-of-two slots
    function automatic logic [`ECC_POS_WIDTH-1:0] ecc_data_pos(input int unsigned index);
        int unsigned pos;
        pos = index + 1;
        for (int k = 0; k < `ECC_POS_WIDTH; k++) begin
            if ((1 << k) <= pos) begin
                pos = pos + 1; // a check-bit slot sits at or below us
            end
        end
        return pos[`ECC_POS_WIDTH-1:0];
    endfunction

endpackage

`default_nettype wire

/* verilog/ecc_encoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ecc_defs.svh"

module ecc_encoder
    import ecc_code_pkg::*;
(
    input  ecc_data_t   data,
    output ecc_parity_t parity
);

    // ========================================
    // check bit generation
    // ========================================

    // every data bit feeds the check bits named by the set bits of its
    // Hamming position
    always_comb begin
        logic [`ECC_POS_WIDTH-1:0] pos;

        parity = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            pos = ecc_data_pos(i);

            for (int k = 0; k < `ECC_POS_WIDTH; k++) begin
                if (pos[k]) begin
                    parity[k] = parity[k] ^ data[i];
                end
            end

            // even-weight positions feed the top bit so that it becomes the
            // parity over the whole codeword
            if (!(^pos)) begin
                parity[`ECC_PARITY_WIDTH-1] = parity[`ECC_PARITY_WIDTH-1] ^ data[i];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/ecc_input_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ecc_defs.svh"

module ecc_input_buffer
    import ecc_stream_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  ecc_req_t in_req,
    output logic     in_credit,
    output logic     buf_valid,
    output ecc_req_t buf_req,
    input  logic     buf_pop
);

    localparam int PTR_W = $clog2(`ECC_CREDITS);
    localparam int CNT_W = $clog2(`ECC_CREDITS + 1);

    ecc_req_t             mem [`ECC_CREDITS];
    logic     [PTR_W-1:0] wr_ptr;
    logic     [PTR_W-1:0] rd_ptr;
    logic     [CNT_W-1:0] count;
    logic                 pop;

    assign buf_valid = count != '0;
    assign buf_req   = mem[rd_ptr];
    assign pop       = buf_pop && buf_valid;

    // the sender only pushes while it holds a credit, so there is always room
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            in_credit <= pop; // hand the slot back one cycle after it frees up
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(`ECC_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`ECC_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/ecc_secded_top.sv */
`timescale 1ns/1ns
`default_nettype none

module ecc_secded_top
    import ecc_code_pkg::*;
    import ecc_stream_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  ecc_data_t   enc_data,
    output ecc_parity_t enc_parity,
    input  logic        in_valid,
    input  ecc_req_t    in_req,
    output logic        in_credit,
    input  logic        out_credit,
    output logic        out_valid,
    output ecc_rsp_t    out_rsp
);

    logic     buf_valid;
    ecc_req_t buf_req;
    logic     buf_pop;

    // write side, check bits for the word about to be stored
    ecc_encoder u_write_encoder (
        .data   (enc_data),
        .parity (enc_parity)
    );

    ecc_input_buffer u_input_buffer (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .in_credit (in_credit),
        .buf_valid (buf_valid),
        .buf_req   (buf_req),
        .buf_pop   (buf_pop)
    );

    ecc_check_pipe u_check_pipe (
        .clk        (clk),
        .rst        (rst),
        .buf_valid  (buf_valid),
        .buf_req    (buf_req),
        .buf_pop    (buf_pop),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_rsp    (out_rsp)
    );

endmodule

`default_nettype wire

/* verilog/ecc_stream_pkg.sv */
`default_nettype none

package ecc_stream_pkg;

    import ecc_code_pkg::*;

    // one read request as it arrives from memory
    typedef struct packed {
        ecc_data_t   data;
        ecc_parity_t parity;
        logic        bypass; // pass data through without checking
    } ecc_req_t;

    // one checked read response
    typedef struct packed {
        ecc_data_t data;
        logic      sbit_err; // single error seen, data corrected
        logic      dbit_err; // double error seen, data left as received
    } ecc_rsp_t;

endpackage

`default_nettype wire

/* verilog/ecc_syndrome_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ecc_defs.svh"

module ecc_syndrome_decoder
    import ecc_code_pkg::*;
(
    input  ecc_syndrome_u syndrome,
    output ecc_data_t     mask,
    output logic          sbit_err,
    output logic          dbit_err
);

    logic odd_weight;
    logic pos_in_range;

    // ========================================
    // error classification
    // ========================================

    // a single flipped bit always leaves an odd number of ones in the syndrome
    assign odd_weight = syndrome.fields.overall ^ (^syndrome.fields.position);

    // zero and every power of two up to 64 lie inside the range as well, so
    // this covers check-bit errors and data-bit errors alike
    assign pos_in_range = syndrome.fields.position <= `ECC_LAST_POSITION;

    assign sbit_err = odd_weight && pos_in_range;

    // anything else non-zero cannot be traced to one bit
    assign dbit_err = (syndrome.raw != '0) && !sbit_err;

    // ========================================
    // correction mask
    // ========================================

    // at most one bit is set, and only when the position names a data bit
    always_comb begin
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            mask[i] = sbit_err && (syndrome.fields.position == ecc_data_pos(i));
        end
    end

endmodule

`default_nettype wire
